/* logic/cfo_pkg.sv */
`default_nettype none

package cfo_pkg;

    // correlation word holds imaginary in the upper half and real in the lower half
    localparam int CORR_W = 32;
    localparam int PART_W = CORR_W / 2;

    // width of each scaled product part fed to the angle engine
    localparam int PROD_W = 16;

    // normalized angle, full scale is +-pi
    localparam int CFO_W = 20;

    // quotient bits and table depth, kept small for simulation
    localparam int LUT_ADDR_W = 12;
    // table covers 0..pi/4 only, so three bits fewer than the angle
    localparam int LUT_OUT_W = CFO_W - 3;

    localparam int NUM_PATHS = 2;
    localparam int PATH_W = (NUM_PATHS > 1) ? $clog2(NUM_PATHS) : 1;

    localparam logic signed [CFO_W-1:0] PI_HALF = CFO_W'(2 ** (CFO_W - 2) - 1);
    localparam logic signed [CFO_W-1:0] PI_QUARTER = CFO_W'(2 ** (CFO_W - 3) - 1);

    // engine sequencing: one quotient bit per divide step, four rotate stages
    localparam int DIV_STEPS = LUT_ADDR_W + 1;
    localparam int ROT_STAGES = 4;
    localparam int STEP_W = $clog2(DIV_STEPS);
    localparam logic [STEP_W-1:0] DIV_LAST = STEP_W'(DIV_STEPS - 1);
    localparam logic [STEP_W-1:0] ROT_LAST = STEP_W'(ROT_STAGES - 1);

    // start to done: IDLE, LOAD, DIVIDE, ROTATE, EMIT, registered done
    localparam int ENGINE_LAT = DIV_STEPS + ROT_STAGES + 3;

    typedef logic [PATH_W-1:0] path_t;
    typedef logic signed [CFO_W-1:0] angle_t;

    typedef struct packed {
        logic [CORR_W-1:0] c0;
        logic [CORR_W-1:0] c1;
    } corr_pair_t;

    typedef struct packed {
        logic signed [PROD_W-1:0] re;
        logic signed [PROD_W-1:0] im;
    } cplx_prod_t;

    typedef struct packed {
        path_t      path;
        cplx_prod_t prod;
    } angle_req_t;

    typedef struct packed {
        path_t  path;
        angle_t angle;
    } cfo_result_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        DIVIDE,
        ROTATE,
        EMIT
    } engine_state_e;

endpackage

`default_nettype wire

/* logic/cplx_conj_mult.sv */
`timescale 1ns/1ps
`default_nettype none

module cplx_conj_mult (
    input  wire                        clk_i,
    input  wire                        reset_ni,
    input  wire cfo_pkg::corr_pair_t   corr_i,
    input  wire                        valid_i,
    output cfo_pkg::cplx_prod_t        prod_o,
    output logic                       valid_o
);

    // stage 1 operand registers
    logic signed [cfo_pkg::PART_W-1:0] a_re_q;
    logic signed [cfo_pkg::PART_W-1:0] a_im_q;
    logic signed [cfo_pkg::PART_W-1:0] b_re_q;
    logic signed [cfo_pkg::PART_W-1:0] b_im_q;
    logic                              vld_q;

    // partial products
    logic signed [cfo_pkg::CORR_W-1:0] p_rr;
    logic signed [cfo_pkg::CORR_W-1:0] p_ii;
    logic signed [cfo_pkg::CORR_W-1:0] p_ir;
    logic signed [cfo_pkg::CORR_W-1:0] p_ri;

    // one guard bit so the sums never wrap
    logic signed [cfo_pkg::CORR_W:0] re_sum;
    logic signed [cfo_pkg::CORR_W:0] im_sum;

    always_ff @(posedge clk_i) begin
        a_re_q <= corr_i.c0[cfo_pkg::PART_W-1:0];
        a_im_q <= corr_i.c0[cfo_pkg::CORR_W-1:cfo_pkg::PART_W];
        b_re_q <= corr_i.c1[cfo_pkg::PART_W-1:0];
        b_im_q <= corr_i.c1[cfo_pkg::CORR_W-1:cfo_pkg::PART_W];
    end

    assign p_rr = a_re_q * b_re_q;
    assign p_ii = a_im_q * b_im_q;
    assign p_ir = a_im_q * b_re_q;
    assign p_ri = a_re_q * b_im_q;

    // c0 * conj(c1): re = ar*br + ai*bi, im = ai*br - ar*bi
    assign re_sum = {p_rr[cfo_pkg::CORR_W-1], p_rr} + {p_ii[cfo_pkg::CORR_W-1], p_ii};
    assign im_sum = {p_ir[cfo_pkg::CORR_W-1], p_ir} - {p_ri[cfo_pkg::CORR_W-1], p_ri};

    // keep the top bits of each sum, half scale of the full product
    always_ff @(posedge clk_i) begin
        prod_o.re <= re_sum[cfo_pkg::CORR_W -: cfo_pkg::PROD_W];
        prod_o.im <= im_sum[cfo_pkg::CORR_W -: cfo_pkg::PROD_W];
    end

    // strobe follows the data through both stages
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            vld_q   <= 1'b0;
            valid_o <= 1'b0;
        end else begin
            vld_q   <= valid_i;
            valid_o <= vld_q;
        end
    end

endmodule

`default_nettype wire

/* logic/angle_request_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module angle_request_arbiter (
    input  wire                                               clk_i,
    input  wire                                               reset_ni,
    input  wire cfo_pkg::cplx_prod_t [cfo_pkg::NUM_PATHS-1:0] prod_i,
    input  wire [cfo_pkg::NUM_PATHS-1:0]                      prod_valid_i,
    input  wire                                               engine_busy_i,
    output cfo_pkg::angle_req_t                               req_o,
    output logic                                              start_o,
    output logic [cfo_pkg::NUM_PATHS-1:0]                     overrun_o
);

    // one pending product per path
    logic [cfo_pkg::NUM_PATHS-1:0]                pend_q;
    cfo_pkg::cplx_prod_t [cfo_pkg::NUM_PATHS-1:0] slot_q;
    cfo_pkg::path_t                               last_q;

    cfo_pkg::path_t                grant_idx;
    logic                          grant_vld;
    logic [cfo_pkg::NUM_PATHS-1:0] grant_mask;

    // round-robin search starting after the last path served
    always_comb begin
        int idx;
        grant_vld = 1'b0;
        grant_idx = last_q;
        for (int k = 1; k <= cfo_pkg::NUM_PATHS; k++) begin
            idx = (int'(last_q) + k) % cfo_pkg::NUM_PATHS;
            if (!grant_vld && pend_q[idx]) begin
                grant_vld = 1'b1;
                grant_idx = cfo_pkg::path_t'(idx);
            end
        end
    end

    assign start_o = grant_vld && !engine_busy_i;
    assign req_o.path = grant_idx;
    assign req_o.prod = slot_q[grant_idx];

    always_comb begin
        for (int p = 0; p < cfo_pkg::NUM_PATHS; p++) begin
            grant_mask[p] = start_o && (grant_idx == cfo_pkg::path_t'(p));
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            pend_q    <= '0;
            overrun_o <= '0;
            last_q    <= cfo_pkg::path_t'(cfo_pkg::NUM_PATHS - 1);
        end else begin
            for (int p = 0; p < cfo_pkg::NUM_PATHS; p++) begin
                // a granted slot may take a new product in the same cycle
                if (prod_valid_i[p]) begin
                    pend_q[p] <= 1'b1;
                end else if (grant_mask[p]) begin
                    pend_q[p] <= 1'b0;
                end
                overrun_o[p] <= prod_valid_i[p] && pend_q[p] && !grant_mask[p];
            end
            if (start_o) begin
                last_q <= grant_idx;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int p = 0; p < cfo_pkg::NUM_PATHS; p++) begin
            if (prod_valid_i[p]) begin
                slot_q[p] <= prod_i[p];
            end
        end
    end

    // engine must raise busy in the cycle after it is started
    a_no_back_to_back: assert property (@(posedge clk_i) disable iff (!reset_ni)
        start_o |=> !start_o);

endmodule

`default_nettype wire

/* logic/angle_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module angle_engine (
    input  wire                       clk_i,
    input  wire                       reset_ni,
    input  wire cfo_pkg::angle_req_t  req_i,
    input  wire                       start_i,
    output logic                      busy_o,
    output cfo_pkg::cfo_result_t      result_o,
    output logic                      done_o
);

    cfo_pkg::engine_state_e      state_q;
    logic [cfo_pkg::STEP_W-1:0]  step_q;

    cfo_pkg::angle_req_t         req_q;
    logic                        swap_q;
    logic                        re_neg_q;
    logic                        im_neg_q;

    // divider
    logic [cfo_pkg::PROD_W-1:0]     den_q;
    logic [cfo_pkg::PROD_W:0]       rem_q;
    logic [cfo_pkg::PROD_W:0]       rem_next;
    logic                           q_bit;
    logic [cfo_pkg::LUT_ADDR_W:0]   quot_q;

    // table and correction pipeline
    logic [cfo_pkg::LUT_ADDR_W-1:0] addr_q;
    logic [cfo_pkg::LUT_OUT_W-1:0]  lut_q;
    cfo_pkg::angle_t                lut_ext;
    cfo_pkg::angle_t                oct_q;
    cfo_pkg::angle_t                angle_q;

    logic [cfo_pkg::PROD_W-1:0]     abs_re;
    logic [cfo_pkg::PROD_W-1:0]     abs_im;
    logic                           swap_d;

    logic [cfo_pkg::LUT_OUT_W-1:0]  atan_lut [2 ** cfo_pkg::LUT_ADDR_W];

    function automatic logic [cfo_pkg::PROD_W-1:0] mag(
        input logic signed [cfo_pkg::PROD_W-1:0] v
    );
        return v[cfo_pkg::PROD_W-1] ? -v : v;
    endfunction

    // atan(idx / full scale), with pi/4 landing on PI_QUARTER
    function automatic logic [cfo_pkg::LUT_OUT_W-1:0] atan_entry(input int idx);
        real ratio;
        real scaled;
        int  rounded;
        ratio   = real'(idx) / real'(2 ** cfo_pkg::LUT_ADDR_W - 1);
        scaled  = $atan(ratio) / $atan(1.0) * real'(cfo_pkg::PI_QUARTER);
        rounded = $rtoi(scaled + 0.5);
        return rounded[cfo_pkg::LUT_OUT_W-1:0];
    endfunction

    initial begin
        for (int i = 0; i < 2 ** cfo_pkg::LUT_ADDR_W; i++) begin
            atan_lut[i] = atan_entry(i);
        end
    end

    assign busy_o = (state_q != cfo_pkg::IDLE);

    // smaller magnitude goes over the larger one
    assign abs_re = mag(req_q.prod.re);
    assign abs_im = mag(req_q.prod.im);
    assign swap_d = (abs_im > abs_re);

    // one restoring step; a zero divisor leaves the quotient at zero
    assign q_bit    = (den_q != '0) && (rem_q >= {1'b0, den_q});
    assign rem_next = q_bit ? rem_q - {1'b0, den_q} : rem_q;

    assign lut_ext = {{(cfo_pkg::CFO_W - cfo_pkg::LUT_OUT_W){1'b0}}, lut_q};

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= cfo_pkg::IDLE;
            step_q  <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= (state_q == cfo_pkg::EMIT);
            case (state_q)
                cfo_pkg::IDLE: begin
                    if (start_i) begin
                        state_q <= cfo_pkg::LOAD;
                    end
                end
                cfo_pkg::LOAD: begin
                    state_q <= cfo_pkg::DIVIDE;
                    step_q  <= cfo_pkg::DIV_LAST;
                end
                cfo_pkg::DIVIDE: begin
                    if (step_q == '0) begin
                        state_q <= cfo_pkg::ROTATE;
                        step_q  <= cfo_pkg::ROT_LAST;
                    end else begin
                        step_q <= step_q - 1'b1;
                    end
                end
                cfo_pkg::ROTATE: begin
                    // wait for the table read and both corrections to settle
                    if (step_q == '0) begin
                        state_q <= cfo_pkg::EMIT;
                    end else begin
                        step_q <= step_q - 1'b1;
                    end
                end
                cfo_pkg::EMIT: begin
                    state_q <= cfo_pkg::IDLE;
                end
                default: begin
                    state_q <= cfo_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == cfo_pkg::IDLE && start_i) begin
            req_q <= req_i;
        end
        if (state_q == cfo_pkg::LOAD) begin
            swap_q   <= swap_d;
            re_neg_q <= req_q.prod.re[cfo_pkg::PROD_W-1];
            im_neg_q <= req_q.prod.im[cfo_pkg::PROD_W-1];
            den_q    <= swap_d ? abs_im : abs_re;
            rem_q    <= {1'b0, (swap_d ? abs_re : abs_im)};
            quot_q   <= '0;
        end
        if (state_q == cfo_pkg::DIVIDE) begin
            rem_q  <= {rem_next[cfo_pkg::PROD_W-1:0], 1'b0};
            quot_q <= {quot_q[cfo_pkg::LUT_ADDR_W-1:0], q_bit};
        end

        // equal magnitudes give a quotient of one, clamp to the last entry
        addr_q <= quot_q[cfo_pkg::LUT_ADDR_W] ? '1 : quot_q[cfo_pkg::LUT_ADDR_W-1:0];
        lut_q  <= atan_lut[addr_q];

        // swapped ratio mirrors the angle about pi/2
        oct_q <= swap_q ? cfo_pkg::PI_HALF - lut_ext : lut_ext;

        case ({re_neg_q, im_neg_q})
            2'b00:   angle_q <= oct_q;
            2'b10:   angle_q <= cfo_pkg::PI_HALF + (cfo_pkg::PI_HALF - oct_q);
            2'b11:   angle_q <= oct_q - cfo_pkg::PI_HALF - cfo_pkg::PI_HALF;
            default: angle_q <= -oct_q;
        endcase

        if (state_q == cfo_pkg::EMIT) begin
            result_o.path  <= req_q.path;
            result_o.angle <= angle_q;
        end
    end

    a_done_pulse: assert property (@(posedge clk_i) disable iff (!reset_ni)
        done_o |=> !done_o);

    a_fixed_latency: assert property (@(posedge clk_i) disable iff (!reset_ni)
        (start_i && !busy_o) |-> ##(cfo_pkg::ENGINE_LAT) done_o);

endmodule

`default_nettype wire

/* logic/cfo_estimator.sv */
`timescale 1ns/1ps
`default_nettype none

module cfo_estimator (
    input  wire                                               clk_i,
    input  wire                                               reset_ni,
    input  wire cfo_pkg::corr_pair_t [cfo_pkg::NUM_PATHS-1:0] corr_i,
    input  wire [cfo_pkg::NUM_PATHS-1:0]                      corr_valid_i,
    output cfo_pkg::cfo_result_t                              cfo_o,
    output logic                                              cfo_valid_o,
    output logic [cfo_pkg::NUM_PATHS-1:0]                     overrun_o
);

    cfo_pkg::cplx_prod_t [cfo_pkg::NUM_PATHS-1:0] prod;
    logic [cfo_pkg::NUM_PATHS-1:0]                prod_valid;

    cfo_pkg::angle_req_t req;
    logic                start;
    logic                busy;

    // antenna 0
    cplx_conj_mult u_mult0 (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .corr_i   (corr_i[0]),
        .valid_i  (corr_valid_i[0]),
        .prod_o   (prod[0]),
        .valid_o  (prod_valid[0])
    );

    // antenna 1
    cplx_conj_mult u_mult1 (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .corr_i   (corr_i[1]),
        .valid_i  (corr_valid_i[1]),
        .prod_o   (prod[1]),
        .valid_o  (prod_valid[1])
    );

    angle_request_arbiter u_arbiter (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .prod_i        (prod),
        .prod_valid_i  (prod_valid),
        .engine_busy_i (busy),
        .req_o         (req),
        .start_o       (start),
        .overrun_o     (overrun_o)
    );

    angle_engine u_engine (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .req_i    (req),
        .start_i  (start),
        .busy_o   (busy),
        .result_o (cfo_o),
        .done_o   (cfo_valid_o)
    );

endmodule

`default_nettype wire

/* sim/cfo_estimator_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cfo_estimator_tb;

    typedef struct packed {
        cfo_pkg::angle_t angle;
        logic [31:0]     strobe;
        logic            timed;
    } expect_t;

    // engine start to done, and corr_valid_i to cfo_valid_o on an idle system
    localparam int ENGINE_CYCLES = 20;
    localparam int IDLE_LATENCY = 23;

    logic                                         clk_i;
    logic                                         reset_ni;
    cfo_pkg::corr_pair_t [cfo_pkg::NUM_PATHS-1:0] corr;
    logic [cfo_pkg::NUM_PATHS-1:0]                corr_valid;
    cfo_pkg::cfo_result_t                         cfo;
    logic                                         cfo_valid;
    logic [cfo_pkg::NUM_PATHS-1:0]                overrun;

    // trace contents, one entry per line
    int          t_test [64];
    int          t_gap [64];
    int          t_path [64];
    logic [31:0] t_c0 [64];
    logic [31:0] t_c1 [64];
    int          t_angle [64];
    int          t_ovr [64];
    int          n_lines = 0;

    expect_t exp_q [cfo_pkg::NUM_PATHS][$];
    int      ovr_due [cfo_pkg::NUM_PATHS][$];
    int      cycle_cnt = 0;
    int      last_served = 1;
    int      check_count = 0;
    int      err_count = 0;
    int      limit_cycles = 0;

    cfo_estimator u_dut (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .corr_i       (corr),
        .corr_valid_i (corr_valid),
        .cfo_o        (cfo),
        .cfo_valid_o  (cfo_valid),
        .overrun_o    (overrun)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic check_result(input cfo_pkg::cfo_result_t got);
        expect_t e;
        expect_t oe;
        int      p;
        int      lat;
        logic    other_pend;
        p = int'(got.path);
        if (exp_q[p].size() == 0) begin
            err_count++;
            $display("result on path %0d at %0t with no sample outstanding", p, $time);
            return;
        end
        e = exp_q[p].pop_front();
        other_pend = 1'b0;
        if (exp_q[1-p].size() > 0) begin
            oe = exp_q[1-p][0];
            // other product already waiting in its slot when this one was granted
            other_pend = (int'(oe.strobe) + 3 <= cycle_cnt - ENGINE_CYCLES);
        end
        check_count++;
        if (other_pend && p == last_served) begin
            err_count++;
            $display("** Error at %0t: cfo_o.path expected %0d got %0d", $time, 1 - p, p);
        end
        last_served = p;
        if (got.angle !== e.angle) begin
            err_count++;
            $display("** Error at %0t: cfo_o.angle (path %0d) expected %0d got %0d",
                     $time, p, e.angle, got.angle);
        end
        if (e.timed) begin
            // two multiplier stages and one arbiter cycle ahead of the engine
            lat = cycle_cnt - int'(e.strobe);
            if (lat != IDLE_LATENCY) begin
                err_count++;
                $display("** Error at %0t: cfo_valid_o latency expected %0d got %0d",
                         $time, IDLE_LATENCY, lat);
            end
        end
    endtask

    task automatic check_overrun(input int p, input logic exp_bit);
        if (exp_bit) begin
            check_count++;
        end
        if (overrun[p] !== exp_bit) begin
            err_count++;
            $display("** Error at %0t: overrun_o[%0d] expected %0b got %0b",
                     $time, p, exp_bit, overrun[p]);
        end
    endtask

    // outputs are sampled at the falling edge
    always @(negedge clk_i) begin
        logic due;
        if (reset_ni) begin
            if (cfo_valid) begin
                check_result(cfo);
            end
            for (int p = 0; p < cfo_pkg::NUM_PATHS; p++) begin
                due = (ovr_due[p].size() > 0) && (ovr_due[p][0] == cycle_cnt);
                check_overrun(p, due);
                if (due) begin
                    void'(ovr_due[p].pop_front());
                end
            end
        end
    end

    task automatic apply_reset();
        corr_valid = '0;
        reset_ni = 1'b0;
        for (int p = 0; p < cfo_pkg::NUM_PATHS; p++) begin
            exp_q[p].delete();
            ovr_due[p].delete();
        end
        // round-robin restarts with path 0
        last_served = 1;
        repeat (5) @(posedge clk_i);
        #1 reset_ni = 1'b1;
    endtask

    task automatic drive_sample(input int i);
        expect_t e;
        int      p;
        p = t_path[i];
        e.timed = (exp_q[0].size() == 0) && (exp_q[1].size() == 0);
        if (t_ovr[i] != 0) begin
            // the pending product is overwritten and never produces a result
            if (exp_q[p].size() > 0) begin
                void'(exp_q[p].pop_back());
            end
            ovr_due[p].push_back(cycle_cnt + 3);
        end
        e.angle = cfo_pkg::angle_t'(t_angle[i]);
        e.strobe = cycle_cnt;
        exp_q[p].push_back(e);
        corr[p].c0 = t_c0[i];
        corr[p].c1 = t_c1[i];
        corr_valid[p] = 1'b1;
    endtask

    task automatic read_trace();
        int          fd;
        int          n;
        int          v_test;
        int          v_gap;
        int          v_path;
        int          v_angle;
        int          v_ovr;
        logic [31:0] v_c0;
        logic [31:0] v_c1;
        string       line;
        fd = $fopen("sim/cfo_trace.txt", "r");
        if (fd == 0) begin
            err_count++;
            $display("could not open the trace file sim/cfo_trace.txt");
        end else begin
            while (!$feof(fd) && n_lines < 64) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line.getc(0) != 8'h23) begin
                    n = $sscanf(line, "%d %d %d %h %h %d %d", v_test, v_gap, v_path,
                                v_c0, v_c1, v_angle, v_ovr);
                    if (n == 7) begin
                        t_test[n_lines] = v_test;
                        t_gap[n_lines] = v_gap;
                        t_path[n_lines] = v_path;
                        t_c0[n_lines] = v_c0;
                        t_c1[n_lines] = v_c1;
                        t_angle[n_lines] = v_angle;
                        t_ovr[n_lines] = v_ovr;
                        n_lines++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        int idx;
        int cur;
        int err_start;
        int chk_start;
        int budget;
        reset_ni = 1'b0;
        corr = '0;
        corr_valid = '0;
        read_trace();
        budget = 0;
        for (int i = 0; i < n_lines; i++) begin
            budget += t_gap[i] + 30;
        end
        limit_cycles = budget;
        repeat (5) @(posedge clk_i);
        #1 reset_ni = 1'b1;
        idx = 0;
        while (idx < n_lines) begin
            cur = t_test[idx];
            err_start = err_count;
            chk_start = check_count;
            while (idx < n_lines && t_test[idx] == cur) begin
                repeat (t_gap[idx]) begin
                    @(posedge clk_i);
                    #1 corr_valid = '0;
                end
                // path 7 in the trace stands for a reset
                if (t_path[idx] == 7) begin
                    apply_reset();
                end else begin
                    drive_sample(idx);
                end
                idx++;
            end
            @(posedge clk_i);
            #1 corr_valid = '0;
            while (exp_q[0].size() > 0 || exp_q[1].size() > 0 ||
                   ovr_due[0].size() > 0 || ovr_due[1].size() > 0) begin
                @(posedge clk_i);
            end
            repeat (10) @(posedge clk_i);
            $display("test %0d finished: %0d checks, %0d errors", cur,
                     check_count - chk_start, err_count - err_start);
        end
        $display("checks passed %0d, errors %0d", check_count - err_count, err_count);
        if (err_count == 0 && n_lines > 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk_i);
        $display("watchdog expired after %0d cycles, results still outstanding", limit_cycles);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/cfo_trace.txt */
# test gap path c0 c1 angle overrun; c0/c1 hex with imag in upper half
# gap counts cycles after the previous line, path 7 applies a reset
1 10 0 1F401F40 00004000 131071 0
2 30 0 1F40E0C0 00004000 393215 0
2 30 1 E0C0E0C0 00004000 -393215 0
2 30 0 E0C01F40 00004000 -131071 0
2 30 1 1F400000 00004000 262143 0
2 30 0 E0C00000 00004000 -262143 0
2 30 1 0000E0C0 00004000 524286 0
2 30 0 00001F40 00004000 0 0
2 30 1 1F401F40 40000000 -131071 0
3 5 7 0 0 0 0
3 10 0 1F401F40 00004000 131071 0
3 0 1 E0C0E0C0 00004000 -393215 0
4 10 0 1F40E0C0 00004000 393215 0
4 0 1 E0C01F40 00004000 -131071 0
4 40 0 1F400000 00004000 262143 0
4 0 1 00001F40 00004000 0 0
4 40 0 0000E0C0 00004000 524286 0
4 0 1 E0C00000 00004000 -262143 0
4 40 0 1F401F40 40000000 -131071 0
4 0 1 1F401F40 00004000 131071 0
5 10 0 00001F40 00004000 0 0
5 5 1 1F400000 00004000 262143 0
5 4 1 E0C0E0C0 00004000 -393215 1
6 10 0 1F401F40 00004000 131071 0
6 6 7 0 0 0 0
6 40 1 1F40E0C0 00004000 393215 0

/* cfo_estimator.f */
logic/cfo_pkg.sv
logic/cplx_conj_mult.sv
logic/angle_request_arbiter.sv
logic/angle_engine.sv
logic/cfo_estimator.sv
sim/cfo_estimator_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the CFO estimator testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module cfo_estimator_tb \
    -f cfo_estimator.f -o cfo_sim \
    && ./obj_dir/cfo_sim > sim.log 2>&1 \
    || { echo "build or simulation run failed"; exit 1; }

grep -q "Finished with errors" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "FAIL, no result in sim.log"; exit 1; }
echo "PASS"
exit 0
